/* Makefile */
# Verilator build and run of the gate activation testbench

.PHONY: sim clean

sim:
	verilator --binary -f sources.f --top-module dnc_gate_tb -o dnc_gate_sim
	out="$$(./obj_dir/dnc_gate_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* design/dnc_gate_collect.sv */
////////////////////
// Output register slice for the activated gate vector
// Holds the vector until out_ready and drives the shared advance
////////////////////

`timescale 1ns/1ps

module dnc_gate_collect #(
  parameter int num_gates = 4
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           res_valid,
  input  logic [dnc_gate_pkg::gate_width-1:0]            res_data [num_gates],
  input  logic                                           out_ready,
  output logic                                           advance,
  output logic                                           out_valid,
  output logic [num_gates*dnc_gate_pkg::gate_width-1:0]  out_data
);

  import dnc_gate_pkg::*;

  // Lane results packed, lane 0 in the low bits
  logic [num_gates*gate_width-1:0] res_flat;

  ////////////////////
  // Pack lanes
  ////////////////////

  for (genvar g = 0; g < num_gates; g++) begin : g_pack
    assign res_flat[g*gate_width +: gate_width] = res_data[g];
  end

  ////////////////////
  // Flow control
  ////////////////////

  // Empty slot or the consumer takes the held vector
  assign advance = ~out_valid | out_ready;

  // Occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= res_valid;
    end
  end

  // Payload stays stable while stalled
  always_ff @(posedge clk) begin
    if (advance & res_valid) begin
      out_data <= res_flat;
    end
  end

endmodule

/* design/dnc_gate_dispatch.sv */
////////////////////
// Input register slice for the gate vector
// Accepts one vector per valid/ready transfer and fans it out to the lanes
// Loads on pipeline advance or when empty
////////////////////

`timescale 1ns/1ps

module dnc_gate_dispatch #(
  parameter int num_gates = 4
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           in_valid,
  input  logic [num_gates*dnc_gate_pkg::gate_width-1:0]  in_data,
  input  logic                                           advance,
  output logic                                           in_ready,
  output logic                                           lane_valid,
  output logic [dnc_gate_pkg::gate_width-1:0]            lane_data [num_gates]
);

  import dnc_gate_pkg::*;

  // Set one edge after reset is released
  logic                            run_q;
  // Slice occupancy
  logic                            valid_q;
  // Held gate vector, lane 0 in the low bits
  logic [num_gates*gate_width-1:0] data_q;
  // Slice may take a new vector
  logic                            load;

  // Downstream moving or slice empty
  assign load     = advance | ~valid_q;
  assign in_ready = run_q & load;

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (load) begin
        valid_q <= in_valid & run_q;
      end
    end
  end

  // Payload only captured on a real transfer
  always_ff @(posedge clk) begin
    if (in_valid & in_ready) begin
      data_q <= in_data;
    end
  end

  assign lane_valid = valid_q;

  // Per-lane fields of the held vector
  for (genvar g = 0; g < num_gates; g++) begin : g_slice
    assign lane_data[g] = data_q[g*gate_width +: gate_width];
  end

endmodule

/* design/dnc_gate_pkg.sv */
////////////////////
// Shared fixed-point constants for the DNC gate activation stage
// Values are signed Q4.12 in, unsigned Q4.12 out
// Imported by every RTL block and by the testbench model
////////////////////

package dnc_gate_pkg;

  ////////////////////
  // Number format
  ////////////////////

  // Width of one gate value
  localparam int gate_width = 16;
  // Fraction bits of Q4.12
  localparam int frac_bits  = 12;
  // 1.0 in Q4.12
  localparam int one_q      = 1 << frac_bits;

  ////////////////////
  // PLAN segments
  ////////////////////

  // Magnitude breakpoints 1.0, 2.375 and 5.0
  localparam int bp_low   = one_q;
  localparam int bp_mid   = (19 * one_q) / 8;
  localparam int bp_high  = 5 * one_q;

  // Segment offsets 0.5, 0.625 and 0.84375
  localparam int off_low  = one_q / 2;
  localparam int off_mid  = (5 * one_q) / 8;
  localparam int off_high = (27 * one_q) / 32;

endpackage

/* design/dnc_gate_sigmoid.sv */
////////////////////
// One sigmoid lane with the PLAN piecewise-linear approximation
// Two register stages, both held while advance is low
// Shifts and adds only, all shifts truncate
////////////////////

`timescale 1ns/1ps

module dnc_gate_sigmoid (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 advance,
  input  logic                                 lane_valid,
  input  logic [dnc_gate_pkg::gate_width-1:0]  x,
  output logic                                 res_valid,
  output logic [dnc_gate_pkg::gate_width-1:0]  y
);

  import dnc_gate_pkg::*;

  ////////////////////
  // Stage 1 signals
  ////////////////////

  // Most negative input
  localparam logic [gate_width-1:0] min_neg = {1'b1, {(gate_width-1){1'b0}}};
  // Largest positive magnitude
  localparam logic [gate_width-1:0] max_pos = {1'b0, {(gate_width-1){1'b1}}};

  logic                  sign_d;
  logic [gate_width-1:0] mag_d;
  logic [1:0]            seg_d;

  logic                  valid1_q;
  logic                  sign_q;
  logic [gate_width-1:0] mag_q;
  logic [1:0]            seg_q;

  ////////////////////
  // Stage 2 signals
  ////////////////////

  logic [gate_width-1:0] pos_d;
  logic [gate_width-1:0] res_d;

  // Sign and saturated magnitude
  assign sign_d = x[gate_width-1];

  always_comb begin
    if (x == min_neg) begin
      mag_d = max_pos;
    end else if (sign_d) begin
      mag_d = gate_width'(-x);
    end else begin
      mag_d = x;
    end
  end

  // Segment index, 3 is the flat top
  always_comb begin
    if (mag_d >= gate_width'(bp_high)) begin
      seg_d = 2'd3;
    end else if (mag_d >= gate_width'(bp_mid)) begin
      seg_d = 2'd2;
    end else if (mag_d >= gate_width'(bp_low)) begin
      seg_d = 2'd1;
    end else begin
      seg_d = 2'd0;
    end
  end

  // Positive side of the curve
  always_comb begin
    case (seg_q)
      2'd3:    pos_d = gate_width'(one_q);
      2'd2:    pos_d = (mag_q >> 5) + gate_width'(off_high);
      2'd1:    pos_d = (mag_q >> 3) + gate_width'(off_mid);
      default: pos_d = (mag_q >> 2) + gate_width'(off_low);
    endcase
  end

  // Mirror about 0.5 for negative inputs
  assign res_d = sign_q ? gate_width'(one_q) - pos_d : pos_d;

  // Valid pipe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid1_q  <= 1'b0;
      res_valid <= 1'b0;
    end else if (advance) begin
      valid1_q  <= lane_valid;
      res_valid <= valid1_q;
    end
  end

  // Data pipe
  always_ff @(posedge clk) begin
    if (advance) begin
      sign_q <= sign_d;
      mag_q  <= mag_d;
      seg_q  <= seg_d;
      y      <= res_d;
    end
  end

endmodule

/* design/dnc_gate_unit.sv */
////////////////////
// Gate activation stage of the DNC interface
// Dispatch slice, num_gates sigmoid lanes and collect slice
// Four cycles of latency and one vector per cycle when not stalled
////////////////////

`timescale 1ns/1ps

module dnc_gate_unit #(
  parameter int num_gates = 4
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           in_valid,
  input  logic [num_gates*dnc_gate_pkg::gate_width-1:0]  in_data,
  output logic                                           in_ready,
  output logic                                           out_valid,
  output logic [num_gates*dnc_gate_pkg::gate_width-1:0]  out_data,
  input  logic                                           out_ready
);

  import dnc_gate_pkg::*;

  // Shared pipeline enable from collect
  logic                  advance;

  // Dispatch to lanes
  logic                  lane_valid;
  logic [gate_width-1:0] lane_data [num_gates];

  // Lanes to collect, lanes run in lockstep
  logic [num_gates-1:0]  res_valid;
  logic [gate_width-1:0] res_data [num_gates];

  ////////////////////
  // Input slice
  ////////////////////

  dnc_gate_dispatch #(
    .num_gates (num_gates)
  ) i_dnc_gate_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .advance    (advance),
    .in_ready   (in_ready),
    .lane_valid (lane_valid),
    .lane_data  (lane_data)
  );

  ////////////////////
  // Sigmoid lanes
  ////////////////////

  for (genvar g = 0; g < num_gates; g++) begin : g_lane
    dnc_gate_sigmoid i_dnc_gate_sigmoid (
      .clk        (clk),
      .rst_n      (rst_n),
      .advance    (advance),
      .lane_valid (lane_valid),
      .x          (lane_data[g]),
      .res_valid  (res_valid[g]),
      .y          (res_data[g])
    );
  end

  // Output slice, lane 0 valid stands for all lanes
  dnc_gate_collect #(
    .num_gates (num_gates)
  ) i_dnc_gate_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid[0]),
    .res_data  (res_data),
    .out_ready (out_ready),
    .advance   (advance),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

/* dv/dnc_gate_tb.sv */
////////////////////
// Testbench for the DNC gate activation stage
// LFSR stimulus, PLAN reference model and an in-order scoreboard
// Inputs change on the falling edge, outputs sampled mid low phase
////////////////////

`timescale 1ns/1ps

module dnc_gate_tb;

  import dnc_gate_pkg::*;

  localparam int num_gates     = 4;
  localparam int vec_width     = num_gates * gate_width;
  // Isolated + directed + symmetry + streaming + random handshake
  localparam int total_vectors = 1 + 3 + 20 + 300 + 300;
  localparam int timeout_limit = 4 * total_vectors + 100;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  logic [vec_width-1:0] in_data;
  logic                 in_ready;
  logic                 out_valid;
  logic [vec_width-1:0] out_data;
  logic                 out_ready;

  // Scoreboard state
  logic [vec_width-1:0] exp_q [$];
  bit                   sym_q [$];
  bit                   sym_mode;
  bit                   check_gaps;
  bit                   stream_started;
  bit                   stall_prev;
  logic [vec_width-1:0] held_data;
  logic [31:0]          lfsr_state;
  int                   errors;
  int                   checked;
  int                   cycle_count;

  // Directed inputs and hand-checked PLAN results
  logic [gate_width-1:0] dir_x [12] = '{16'h0000, 16'h0800, 16'hF800, 16'h1000,
                                        16'hF000, 16'h2600, 16'hDA00, 16'h5000,
                                        16'hB000, 16'h7FD7, 16'h8029, 16'h8000};
  logic [gate_width-1:0] dir_y [12] = '{16'h0800, 16'h0A00, 16'h0600, 16'h0C00,
                                        16'h0400, 16'h0EB0, 16'h0150, 16'h1000,
                                        16'h0000, 16'h1000, 16'h0000, 16'h0000};

  dnc_gate_unit #(
    .num_gates (num_gates)
  ) i_dnc_gate_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h80200003;
      end
    end
    return v;
  endfunction

  function automatic logic [vec_width-1:0] rand_vector();
    logic [vec_width-1:0] v;
    for (int g = 0; g < num_gates; g++) begin
      v[g*gate_width +: gate_width] = gate_width'(rand_bits(gate_width));
    end
    return v;
  endfunction

  // PLAN sigmoid written from the segment rules
  function automatic logic [gate_width-1:0] plan_sigmoid(input logic [gate_width-1:0] x);
    int v;
    int mag;
    int pos;
    v = int'($signed(x));
    mag = (v < 0) ? -v : v;
    // Most negative input saturates
    if (mag > 32767) begin
      mag = 32767;
    end
    if (mag >= bp_high) begin
      pos = one_q;
    end else if (mag >= bp_mid) begin
      pos = (mag >> 5) + off_high;
    end else if (mag >= bp_low) begin
      pos = (mag >> 3) + off_mid;
    end else begin
      pos = (mag >> 2) + off_low;
    end
    if (v < 0) begin
      pos = one_q - pos;
    end
    return gate_width'(pos);
  endfunction

  function automatic logic [vec_width-1:0] model_vector(input logic [vec_width-1:0] v);
    logic [vec_width-1:0] r;
    for (int g = 0; g < num_gates; g++) begin
      r[g*gate_width +: gate_width] = plan_sigmoid(v[g*gate_width +: gate_width]);
    end
    return r;
  endfunction

  ////////////////////
  // Cycle and scoreboard
  ////////////////////

  // Samples 5 ns before the rising edge, then waits for the next falling edge
  task automatic run_cycle(output logic accepted);
    logic [vec_width-1:0] exp_vec;
    bit                   sym;
    int                   pair_sum;
    #5;
    accepted = in_valid & in_ready;
    if (accepted) begin
      exp_q.push_back(model_vector(in_data));
      sym_q.push_back(sym_mode);
    end
    // Held output must not move under back-pressure
    if (stall_prev) begin
      if (!out_valid) begin
        errors++;
        $display("out_valid dropped while the output was stalled");
      end else if (out_data !== held_data) begin
        errors++;
        $display("Error: out_data changed under stall, %h, held %h", out_data, held_data);
      end
    end
    stall_prev = out_valid & ~out_ready;
    held_data  = out_data;
    // Streaming phase expects back-to-back outputs
    if (check_gaps) begin
      if (out_valid) begin
        stream_started = 1'b1;
      end else if (stream_started && exp_q.size() > 0) begin
        errors++;
        $display("Output gap while streaming with out_ready held high");
      end
    end
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output transfer with no vector outstanding");
      end else begin
        exp_vec = exp_q.pop_front();
        sym     = sym_q.pop_front();
        checked++;
        for (int g = 0; g < num_gates; g++) begin
          if (out_data[g*gate_width +: gate_width] !== exp_vec[g*gate_width +: gate_width]) begin
            errors++;
            $display("Error: out_data lane %0d = %h, expected %h", g,
                     out_data[g*gate_width +: gate_width],
                     exp_vec[g*gate_width +: gate_width]);
          end
        end
        // Lanes 2k and 2k+1 carry x and -x
        if (sym) begin
          for (int g = 0; g < num_gates; g += 2) begin
            pair_sum = int'(out_data[g*gate_width +: gate_width]) +
                       int'(out_data[(g+1)*gate_width +: gate_width]);
            if (pair_sum != one_q) begin
              errors++;
              $display("Error: out_data lanes %0d+%0d sum = %h, expected %h", g, g + 1,
                       pair_sum, one_q);
            end
          end
        end
      end
    end
    @(negedge clk);
  endtask

  task automatic send_vector(input logic [vec_width-1:0] v);
    logic acc;
    in_data  = v;
    in_valid = 1'b1;
    run_cycle(acc);
    while (!acc) begin
      run_cycle(acc);
    end
    in_valid = 1'b0;
  endtask

  task automatic drain_outputs();
    logic acc;
    while (exp_q.size() > 0) begin
      run_cycle(acc);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic                  acc;
    int                    edges;
    int                    sent;
    logic [gate_width-1:0] x0;
    logic [gate_width-1:0] x1;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    lfsr_state = 32'ha4a0;
    errors     = 0;
    checked    = 0;
    sym_mode   = 1'b0;
    check_gaps = 1'b0;
    stream_started = 1'b0;
    stall_prev = 1'b0;
    held_data  = '0;

    // Reset, outputs quiet throughout
    repeat (4) begin
      @(negedge clk);
      if (out_valid !== 1'b0 || in_ready !== 1'b0) begin
        errors++;
        $display("out_valid or in_ready high during reset");
      end
    end
    rst_n = 1'b1;
    run_cycle(acc);

    // Isolated vector, four edges from drive to out_valid
    in_data  = rand_vector();
    in_valid = 1'b1;
    run_cycle(acc);
    in_valid = 1'b0;
    edges = 1;
    if (!acc) begin
      errors++;
      $display("Isolated vector was not accepted after reset");
    end
    while (!out_valid && edges < 8) begin
      run_cycle(acc);
      edges++;
    end
    if (edges != 4) begin
      errors++;
      $display("Isolated vector took %0d edges instead of 4", edges);
    end
    drain_outputs();

    // Directed values, model checked against hand values first
    for (int i = 0; i < 12; i++) begin
      if (plan_sigmoid(dir_x[i]) !== dir_y[i]) begin
        errors++;
        $display("Error: model y for x %h = %h, expected %h", dir_x[i],
                 plan_sigmoid(dir_x[i]), dir_y[i]);
      end
    end
    for (int k = 0; k < 3; k++) begin
      send_vector({dir_x[4*k+3], dir_x[4*k+2], dir_x[4*k+1], dir_x[4*k]});
    end
    drain_outputs();

    // Symmetric pairs, saturated input avoided
    sym_mode = 1'b1;
    for (int k = 0; k < 20; k++) begin
      x0 = gate_width'(rand_bits(gate_width));
      x1 = gate_width'(rand_bits(gate_width));
      if (x0 == 16'h8000) x0 = 16'h7FFF;
      if (x1 == 16'h8000) x1 = 16'h7FFF;
      send_vector({-x1, x1, -x0, x0});
    end
    drain_outputs();
    sym_mode = 1'b0;

    // Full-rate streaming
    check_gaps = 1'b1;
    for (int k = 0; k < 300; k++) begin
      send_vector(rand_vector());
    end
    drain_outputs();
    check_gaps = 1'b0;

    // Random valid and ready on both sides
    sent = 0;
    while (sent < 300) begin
      out_ready = rand_bits(1) != 0;
      if (!in_valid && rand_bits(1) != 0) begin
        in_valid = 1'b1;
        in_data  = rand_vector();
      end
      run_cycle(acc);
      if (acc) begin
        sent++;
        in_valid = 1'b0;
      end
    end
    out_ready = 1'b1;
    drain_outputs();

    $display("Summary: %0d errors, %0d vectors checked", errors, checked);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Run limit from the vector count
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stalled after %0d cycles with %0d vectors outstanding",
             cycle_count, exp_q.size());
    $display("tests failed");
    $finish;
  end

endmodule

/* sources.f */
design/dnc_gate_pkg.sv
design/dnc_gate_dispatch.sv
design/dnc_gate_sigmoid.sv
design/dnc_gate_collect.sv
design/dnc_gate_unit.sv
dv/dnc_gate_tb.sv
